// ==== logic/riscv_defines.sv ====
// Word width, load and store type enums and byte offset width for the writeback path

package riscv_defines;

	//////////////////////////////////////////////////////////////////////
	// Datapath widths
	//////////////////////////////////////////////////////////////////////

	// Data and address word width
	localparam int WORD_WIDTH = 32;

	// Byte offset inside one word
	// Low address bits that pick the lane
	localparam int BYTE_OFS_WIDTH = 2;

	//////////////////////////////////////////////////////////////////////
	// Load types
	//////////////////////////////////////////////////////////////////////

	// Coded by the decode stage
	// Any nonzero value marks a load
	typedef enum logic [2:0] {
		LOAD_NONE = 3'd0,
		// Signed byte
		LOAD_LB   = 3'd1,
		// Signed halfword
		LOAD_LH   = 3'd2,
		// Full word
		LOAD_LW   = 3'd3,
		// Unsigned byte
		LOAD_LBU  = 3'd4,
		// Unsigned halfword
		LOAD_LHU  = 3'd5
	} load_type_e;

	//////////////////////////////////////////////////////////////////////
	// Store types
	//////////////////////////////////////////////////////////////////////

	// Any nonzero value marks a store
	typedef enum logic [1:0] {
		STORE_NONE = 2'd0,
		// Byte store, one lane
		STORE_SB   = 2'd1,
		// Halfword store, two lanes
		STORE_SH   = 2'd2,
		// Word store, all lanes
		STORE_SW   = 2'd3
	} store_type_e;

endpackage

// ==== logic/lsu_store.sv ====
// Store formatter with byte enable decode and lane replicated write data

`timescale 1ns/1ps

module lsu_store (
	// Byte address of the store
	input  logic [riscv_defines::WORD_WIDTH-1:0] addr_i,
	// Raw store data from the register file
	input  logic [riscv_defines::WORD_WIDTH-1:0] wdata_i,
	input  riscv_defines::store_type_e           store_type_i,
	// Lane enables towards memory
	output logic [3:0]                           be_o,
	// Data with the value copied into every lane
	output logic [riscv_defines::WORD_WIDTH-1:0] wdata_o
);

	// Lane selected by the low address bits
	logic [riscv_defines::BYTE_OFS_WIDTH-1:0] byte_ofs;

	assign byte_ofs = addr_i[riscv_defines::BYTE_OFS_WIDTH-1:0];

	//////////////////////////////////////////////////////////////////////
	// Byte enables
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (store_type_i)
			riscv_defines::STORE_SB: begin
				// One lane, picked by the offset
				be_o = 4'b0001 << byte_ofs;
			end
			riscv_defines::STORE_SH: begin
				// Upper or lower half, halfwords are even
				be_o = byte_ofs[1] ? 4'b1100 : 4'b0011;
			end
			riscv_defines::STORE_SW: begin
				be_o = 4'b1111;
			end
			default: begin
				// No store, nothing enabled
				be_o = 4'b0000;
			end
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Lane replication
	//////////////////////////////////////////////////////////////////////

	// The enables decide which copy lands in memory
	always_comb begin
		case (store_type_i)
			riscv_defines::STORE_SB: begin
				wdata_o = {4{wdata_i[7:0]}};
			end
			riscv_defines::STORE_SH: begin
				wdata_o = {2{wdata_i[15:0]}};
			end
			default: begin
				// Word store, or don't care
				wdata_o = wdata_i;
			end
		endcase
	end

endmodule

// ==== logic/lsu_load.sv ====
// Load extractor with lane select and sign or zero extension

`timescale 1ns/1ps

module lsu_load (
	// Whole word returned by memory
	input  logic [riscv_defines::WORD_WIDTH-1:0]     rdata_i,
	// Type and offset of the load being completed
	input  riscv_defines::load_type_e                load_type_i,
	input  logic [riscv_defines::BYTE_OFS_WIDTH-1:0] byte_ofs_i,
	// Extended value for the register file
	output logic [riscv_defines::WORD_WIDTH-1:0]     load_data_o
);

	// Selected lane values before extension
	logic [7:0]  load_byte;
	logic [15:0] load_half;

	//////////////////////////////////////////////////////////////////////
	// Lane select
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (byte_ofs_i)
			2'd0: begin
				load_byte = rdata_i[7:0];
			end
			2'd1: begin
				load_byte = rdata_i[15:8];
			end
			2'd2: begin
				load_byte = rdata_i[23:16];
			end
			default: begin
				load_byte = rdata_i[31:24];
			end
		endcase
	end

	// Halfwords are even, so only bit 1 matters
	assign load_half = byte_ofs_i[1] ? rdata_i[31:16] : rdata_i[15:0];

	//////////////////////////////////////////////////////////////////////
	// Extension
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (load_type_i)
			riscv_defines::LOAD_LB: begin
				// Copy the byte's top bit upwards
				load_data_o = {{(riscv_defines::WORD_WIDTH-8){load_byte[7]}}, load_byte};
			end
			riscv_defines::LOAD_LH: begin
				load_data_o = {{(riscv_defines::WORD_WIDTH-16){load_half[15]}}, load_half};
			end
			riscv_defines::LOAD_LBU: begin
				// Zero fill
				load_data_o = {{(riscv_defines::WORD_WIDTH-8){1'b0}}, load_byte};
			end
			riscv_defines::LOAD_LHU: begin
				load_data_o = {{(riscv_defines::WORD_WIDTH-16){1'b0}}, load_half};
			end
			default: begin
				// LW passes the word untouched
				load_data_o = rdata_i;
			end
		endcase
	end

endmodule

// ==== logic/wb_stage.sv ====
// Writeback stage with memory request tracking, both LSU halves and write data select

`timescale 1ns/1ps

module wb_stage (
	input  logic                                 clk,
	input  logic                                 rst_i,

	// Data memory port
	output logic                                 data_req_o,
	output logic [riscv_defines::WORD_WIDTH-1:0] data_addr_o,
	output logic                                 data_we_o,
	output logic [3:0]                           data_be_o,
	output logic [riscv_defines::WORD_WIDTH-1:0] data_wdata_o,
	input  logic [riscv_defines::WORD_WIDTH-1:0] data_rdata_i,
	input  logic                                 data_rvalid_i,
	input  logic                                 data_gnt_i,

	// Datapath
	input  logic [riscv_defines::WORD_WIDTH-1:0] wb_data_i,
	input  logic [riscv_defines::WORD_WIDTH-1:0] store_data_i,
	output logic [riscv_defines::WORD_WIDTH-1:0] reg_wdata_o,

	// Control
	input  riscv_defines::load_type_e            load_type_i,
	input  riscv_defines::store_type_e           store_type_i,
	output logic                                 load_flag_o,
	output logic                                 load_done_o
);

	logic                                     load_flag;
	logic                                     store_flag;
	logic                                     load_grant;
	// Load waiting for its rvalid
	logic                                     load_pend;
	riscv_defines::load_type_e                pend_type;
	logic [riscv_defines::BYTE_OFS_WIDTH-1:0] pend_ofs;
	logic [riscv_defines::WORD_WIDTH-1:0]     load_data;

	assign load_flag  = (load_type_i != riscv_defines::LOAD_NONE);
	assign store_flag = (store_type_i != riscv_defines::STORE_NONE);

	//////////////////////////////////////////////////////////////////////
	// Memory request
	//////////////////////////////////////////////////////////////////////

	// Held by the core until granted
	assign data_req_o  = load_flag | store_flag;
	assign data_we_o   = store_flag;
	// Word aligned byte address
	assign data_addr_o = {wb_data_i[riscv_defines::WORD_WIDTH-1:riscv_defines::BYTE_OFS_WIDTH],
		{riscv_defines::BYTE_OFS_WIDTH{1'b0}}};

	lsu_store u_lsu_store (
		.addr_i       (wb_data_i),
		.wdata_i      (store_data_i),
		.store_type_i (store_type_i),
		.be_o         (data_be_o),
		.wdata_o      (data_wdata_o)
	);

	//////////////////////////////////////////////////////////////////////
	// Load tracking
	//////////////////////////////////////////////////////////////////////

	assign load_grant = data_req_o & data_gnt_i & load_flag & ~store_flag;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			load_pend <= 1'b0;
		end else if (load_grant) begin
			load_pend <= 1'b1;
		end else if (data_rvalid_i) begin
			load_pend <= 1'b0;
		end
	end

	// Type and offset of the granted load
	always_ff @(posedge clk) begin
		if (load_grant) begin
			pend_type <= load_type_i;
			pend_ofs  <= wb_data_i[riscv_defines::BYTE_OFS_WIDTH-1:0];
		end
	end

	lsu_load u_lsu_load (
		.rdata_i     (data_rdata_i),
		.load_type_i (pend_type),
		.byte_ofs_i  (pend_ofs),
		.load_data_o (load_data)
	);

	//////////////////////////////////////////////////////////////////////
	// Register write data
	//////////////////////////////////////////////////////////////////////

	assign load_done_o = data_rvalid_i & load_pend;
	assign reg_wdata_o = load_done_o ? load_data : wb_data_i;
	assign load_flag_o = load_flag;

endmodule

// ==== logic/data_ram.sv ====
// Byte enabled data RAM with same cycle grant and registered read return

`timescale 1ns/1ps

module data_ram #(
	// Depth in words, a power of two
	parameter int MEM_WORDS = 256
) (
	input  logic                                 clk,
	input  logic                                 rst_i,

	// Request side
	input  logic                                 req_i,
	input  logic [riscv_defines::WORD_WIDTH-1:0] addr_i,
	input  logic                                 we_i,
	input  logic [3:0]                           be_i,
	input  logic [riscv_defines::WORD_WIDTH-1:0] wdata_i,

	// Response side
	output logic                                 gnt_o,
	output logic                                 rvalid_o,
	output logic [riscv_defines::WORD_WIDTH-1:0] rdata_o
);

	localparam int ADDR_BITS = $clog2(MEM_WORDS);

	// Word array
	logic [riscv_defines::WORD_WIDTH-1:0] mem [MEM_WORDS];
	// Word index taken above the byte offset
	logic [ADDR_BITS-1:0]                 word_idx;

	assign word_idx = addr_i[riscv_defines::BYTE_OFS_WIDTH +: ADDR_BITS];

	// Never busy
	assign gnt_o = req_i;

	//////////////////////////////////////////////////////////////////////
	// Write port
	//////////////////////////////////////////////////////////////////////

	// Only enabled lanes change
	always_ff @(posedge clk) begin
		if (req_i && we_i) begin
			for (int i = 0; i < 4; i++) begin
				if (be_i[i]) begin
					mem[word_idx][8*i +: 8] <= wdata_i[8*i +: 8];
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read port
	//////////////////////////////////////////////////////////////////////

	// Data one cycle after the grant
	always_ff @(posedge clk) begin
		if (req_i && !we_i) begin
			rdata_o <= mem[word_idx];
		end
	end

	// One rvalid per granted read, none for writes
	always_ff @(posedge clk) begin
		if (rst_i) begin
			rvalid_o <= 1'b0;
		end else begin
			rvalid_o <= req_i & ~we_i;
		end
	end

endmodule

// ==== logic/wb_top.sv ====
// Top level joining the writeback stage and the data RAM

`timescale 1ns/1ps

module wb_top #(
	parameter int MEM_WORDS = 256
) (
	input  logic                                 clk,
	input  logic                                 rst_i,

	// From the core side
	input  logic [riscv_defines::WORD_WIDTH-1:0] wb_data_i,
	input  logic [riscv_defines::WORD_WIDTH-1:0] store_data_i,
	input  riscv_defines::load_type_e            load_type_i,
	input  riscv_defines::store_type_e           store_type_i,

	// Towards the register file
	output logic [riscv_defines::WORD_WIDTH-1:0] reg_wdata_o,
	output logic                                 load_flag_o,
	output logic                                 load_done_o
);

	// Memory port wires
	logic                                 data_req;
	logic [riscv_defines::WORD_WIDTH-1:0] data_addr;
	logic                                 data_we;
	logic [3:0]                           data_be;
	logic [riscv_defines::WORD_WIDTH-1:0] data_wdata;
	logic                                 data_gnt;
	logic                                 data_rvalid;
	logic [riscv_defines::WORD_WIDTH-1:0] data_rdata;

	wb_stage u_wb_stage (
		.clk           (clk),
		.rst_i         (rst_i),
		.data_req_o    (data_req),
		.data_addr_o   (data_addr),
		.data_we_o     (data_we),
		.data_be_o     (data_be),
		.data_wdata_o  (data_wdata),
		.data_rdata_i  (data_rdata),
		.data_rvalid_i (data_rvalid),
		.data_gnt_i    (data_gnt),
		.wb_data_i     (wb_data_i),
		.store_data_i  (store_data_i),
		.reg_wdata_o   (reg_wdata_o),
		.load_type_i   (load_type_i),
		.store_type_i  (store_type_i),
		.load_flag_o   (load_flag_o),
		.load_done_o   (load_done_o)
	);

	// Depth comes from this level
	data_ram #(
		.MEM_WORDS (MEM_WORDS)
	) u_data_ram (
		.clk      (clk),
		.rst_i    (rst_i),
		.req_i    (data_req),
		.addr_i   (data_addr),
		.we_i     (data_we),
		.be_i     (data_be),
		.wdata_i  (data_wdata),
		.gnt_o    (data_gnt),
		.rvalid_o (data_rvalid),
		.rdata_o  (data_rdata)
	);

endmodule

// ==== test/wb_checker.sv ====
// Byte model of the data memory, per cycle output comparison and error counting

`timescale 1ns/1ps

module wb_checker (
	input  logic                                 clk,
	input  logic                                 rst_i,
	// DUT inputs, as driven by the core side
	input  logic [riscv_defines::WORD_WIDTH-1:0] wb_data_i,
	input  logic [riscv_defines::WORD_WIDTH-1:0] store_data_i,
	input  riscv_defines::load_type_e            load_type_i,
	input  riscv_defines::store_type_e           store_type_i,
	// DUT outputs
	input  logic [riscv_defines::WORD_WIDTH-1:0] reg_wdata_i,
	input  logic                                 load_flag_i,
	input  logic                                 load_done_i,
	output int                                   err_cnt_o
);

	// First 32 words only
	localparam int MODEL_BYTES = 128;

	logic [7:0]  model_mem [MODEL_BYTES];
	// Load issued last cycle and its expected result
	logic        pend;
	logic [31:0] pend_exp;
	int          errors = 0;

	assign err_cnt_o = errors;

	function automatic int byte_idx(logic [31:0] addr);
		return int'(addr[6:0]);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Memory model
	//////////////////////////////////////////////////////////////////////

	// Little endian, lowest address in bits 7:0
	function automatic logic [31:0] expect_load(logic [31:0] addr, riscv_defines::load_type_e lt);
		int          i;
		logic [7:0]  b;
		logic [15:0] h;
		i = byte_idx(addr);
		b = model_mem[i];
		case (lt)
			riscv_defines::LOAD_LB: return {{24{b[7]}}, b};
			riscv_defines::LOAD_LBU: return {24'd0, b};
			riscv_defines::LOAD_LH,
			riscv_defines::LOAD_LHU: begin
				h = {model_mem[i+1], b};
				// Sign bit is the top of the upper byte
				if (lt == riscv_defines::LOAD_LH) begin
					return {{16{h[15]}}, h};
				end
				return {16'd0, h};
			end
			default: return {model_mem[i+3], model_mem[i+2], model_mem[i+1], b};
		endcase
	endfunction

	task automatic apply_store(logic [31:0] addr, logic [31:0] data,
		riscv_defines::store_type_e st);
		int i;
		i = byte_idx(addr);
		model_mem[i] = data[7:0];
		if (st != riscv_defines::STORE_SB) begin
			model_mem[i+1] = data[15:8];
		end
		if (st == riscv_defines::STORE_SW) begin
			model_mem[i+2] = data[23:16];
			model_mem[i+3] = data[31:24];
		end
	endtask

	task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
		if (exp !== act) begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic report_error(string msg);
		errors++;
		$display("ERROR at %0t ns: %s", $time, msg);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Per cycle checks, sampled on the rising edge
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		if (rst_i) begin
			pend = 1'b0;
		end else begin
			check_value("load_flag_o", {31'd0, load_type_i != riscv_defines::LOAD_NONE},
				{31'd0, load_flag_i});
			if (pend) begin
				if (!load_done_i) begin
					report_error("load_done_o stayed low one cycle after a load");
				end else begin
					check_value("reg_wdata_o", pend_exp, reg_wdata_i);
				end
			end else begin
				if (load_done_i) begin
					report_error("load_done_o pulsed with no load outstanding");
				end
				// Plain result passes straight through
				check_value("reg_wdata_o", wb_data_i, reg_wdata_i);
			end
			pend = 1'b0;
			if (store_type_i != riscv_defines::STORE_NONE) begin
				apply_store(wb_data_i, store_data_i, store_type_i);
			end
			if (load_type_i != riscv_defines::LOAD_NONE) begin
				pend_exp = expect_load(wb_data_i, load_type_i);
				pend     = 1'b1;
			end
		end
	end

endmodule

// ==== test/wb_top_tb.sv ====
// Clock, reset, seeded random load and store stimulus, DUT and checker, timeout

`timescale 1ns/1ps

module wb_top_tb;

	localparam int MEM_WORDS    = 256;
	localparam int RESET_CYCLES = 8;
	localparam int WRITE_OPS    = 64;
	localparam int FILL_WORDS   = 32;
	localparam int RAND_OPS     = 300;
	// Worst case is 4 cycles per random op for a store and its checking LW
	localparam int STIM_CYCLES    = 2*WRITE_OPS + 2*FILL_WORDS + 4*RAND_OPS + 4;
	localparam int TIMEOUT_CYCLES = 2*STIM_CYCLES + RESET_CYCLES;

	logic                       clk;
	logic                       rst_i;
	logic [31:0]                wb_data;
	logic [31:0]                store_data;
	riscv_defines::load_type_e  load_type;
	riscv_defines::store_type_e store_type;
	logic [31:0]                reg_wdata;
	logic                       load_flag;
	logic                       load_done;
	int                         errors;
	int                         cycles = 0;
	integer                     seed;

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	wb_top #(
		.MEM_WORDS (MEM_WORDS)
	) DUT (
		.clk          (clk),
		.rst_i        (rst_i),
		.wb_data_i    (wb_data),
		.store_data_i (store_data),
		.load_type_i  (load_type),
		.store_type_i (store_type),
		.reg_wdata_o  (reg_wdata),
		.load_flag_o  (load_flag),
		.load_done_o  (load_done)
	);

	wb_checker u_checker (
		.clk          (clk),
		.rst_i        (rst_i),
		.wb_data_i    (wb_data),
		.store_data_i (store_data),
		.load_type_i  (load_type),
		.store_type_i (store_type),
		.reg_wdata_i  (reg_wdata),
		.load_flag_i  (load_flag),
		.load_done_i  (load_done),
		.err_cnt_o    (errors)
	);

	//////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////////////////////////

	// One core cycle with inputs changed on the falling edge
	task automatic drive(logic [31:0] res, logic [31:0] sdata,
		riscv_defines::load_type_e lt, riscv_defines::store_type_e st);
		@(negedge clk);
		wb_data    = res;
		store_data = sdata;
		load_type  = lt;
		store_type = st;
	endtask

	// Access plus the mandatory bubble
	task automatic mem_op(logic [31:0] addr, logic [31:0] sdata,
		riscv_defines::load_type_e lt, riscv_defines::store_type_e st);
		drive(addr, sdata, lt, st);
		drive($random(seed), 32'd0, riscv_defines::LOAD_NONE, riscv_defines::STORE_NONE);
	endtask

	task automatic next_data(output logic [31:0] d);
		logic [31:0] m;
		d = $random(seed);
		m = $random(seed);
		// Top bit of every byte set now and then so signed loads go negative
		if (m[1:0] == 2'd0) begin
			d = d | 32'h8080_8080;
		end
	endtask

	// Offset aligned down to the access size
	function automatic logic [31:0] make_addr(logic [4:0] word, logic [1:0] ofs, int size);
		case (size)
			1: return {25'd0, word, ofs};
			2: return {25'd0, word, ofs[1], 1'b0};
			default: return {25'd0, word, 2'b00};
		endcase
	endfunction

	task automatic random_store(output logic [31:0] addr);
		logic [31:0]                r;
		logic [31:0]                d;
		riscv_defines::store_type_e st;
		r = $random(seed);
		case (r % 3)
			0: st = riscv_defines::STORE_SB;
			1: st = riscv_defines::STORE_SH;
			default: st = riscv_defines::STORE_SW;
		endcase
		addr = make_addr(r[12:8], r[14:13], (st == riscv_defines::STORE_SB) ? 1 :
			(st == riscv_defines::STORE_SH) ? 2 : 4);
		next_data(d);
		mem_op(addr, d, riscv_defines::LOAD_NONE, st);
	endtask

	task automatic random_load();
		logic [31:0]               r;
		riscv_defines::load_type_e lt;
		int                        size;
		r = $random(seed);
		case (r % 5)
			0: lt = riscv_defines::LOAD_LB;
			1: lt = riscv_defines::LOAD_LH;
			2: lt = riscv_defines::LOAD_LW;
			3: lt = riscv_defines::LOAD_LBU;
			default: lt = riscv_defines::LOAD_LHU;
		endcase
		size = (lt == riscv_defines::LOAD_LW) ? 4 :
			(lt == riscv_defines::LOAD_LH || lt == riscv_defines::LOAD_LHU) ? 2 : 1;
		mem_op(make_addr(r[12:8], r[14:13], size), 32'd0, lt, riscv_defines::STORE_NONE);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		logic [31:0] addr;
		logic [31:0] d;
		logic [31:0] r;
		seed       = 5305;
		rst_i      = 1'b1;
		wb_data    = 32'd0;
		store_data = 32'd0;
		load_type  = riscv_defines::LOAD_NONE;
		store_type = riscv_defines::STORE_NONE;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_i = 1'b0;
		// RAM is not reset so every word gets fully written before loads
		for (int w = 0; w < FILL_WORDS; w++) begin
			next_data(d);
			mem_op({25'd0, w[4:0], 2'b00}, d, riscv_defines::LOAD_NONE, riscv_defines::STORE_SW);
		end
		// Partial stores on top of the filled words
		for (int n = 0; n < WRITE_OPS; n++) begin
			random_store(addr);
		end
		for (int n = 0; n < RAND_OPS; n++) begin
			r = $random(seed);
			case (r % 10)
				0, 1, 2, 3: random_load();
				4, 5, 6: random_store(addr);
				7: begin
					// LW right after shows which lanes the store touched
					random_store(addr);
					mem_op({addr[31:2], 2'b00}, 32'd0, riscv_defines::LOAD_LW,
						riscv_defines::STORE_NONE);
				end
				default: drive($random(seed), 32'd0, riscv_defines::LOAD_NONE,
					riscv_defines::STORE_NONE);
			endcase
		end
		repeat (3) drive(32'd0, 32'd0, riscv_defines::LOAD_NONE, riscv_defines::STORE_NONE);
		// Past the last checking edge so the error count is settled
		@(negedge clk);
		$display("Run finished after %0d cycles with %0d errors", cycles, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

endmodule

// ==== sim.f ====
logic/riscv_defines.sv
logic/lsu_store.sv
logic/lsu_load.sv
logic/wb_stage.sv
logic/data_ram.sv
logic/wb_top.sv
test/wb_checker.sv
test/wb_top_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build with Verilator, run, and decide by the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f sim.f --top-module wb_top_tb -o wb_sim > build.log 2>&1 \
	&& ./obj_dir/wb_sim > sim.log 2>&1 \
	|| { cat build.log; echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -qx "TEST RESULT: PASS" sim.log && echo "Simulation passed" \
	|| { echo "Simulation failed, see sim.log"; exit 1; }
